//--- rtl/spi_bus_pkg.sv
`default_nettype none

package spi_bus_pkg;

    // Processor bus data width
    localparam int BUS_W = 8;

    // Register addresses within the 4-bit window
    typedef enum logic [3:0] {
        ADDR_CTRL = 4'd0, // Control write, status read
        ADDR_TX   = 4'd1, // Queue a byte, read back last written
        ADDR_RX   = 4'd2, // Last received byte
        ADDR_CFG  = 4'd4  // Divider and sampling mode, write only
    } spi_addr_e;

    // Control fields taken from bus bits 3:2
    typedef struct packed {
        logic dc;      // Bus bit 3
        logic end_txn; // Bus bit 2, release select after the byte
    } spi_ctrl_t;

    // Status word returned at ADDR_CTRL
    typedef struct packed {
        logic [3:0] rsvd;       // Always zero
        logic       dc;
        logic       end_txn;
        logic       tx_pending; // A byte waits behind the current one
        logic       busy;       // Engine is shifting
    } spi_status_t;

endpackage

`default_nettype wire

//--- rtl/spi_link_pkg.sv
`default_nettype none

package spi_link_pkg;

    // Divider after reset, half period = divider + 1 clk cycles
    localparam logic [6:0] CFG_RESET_DIV = 7'd3;

    // Link configuration, same layout as the bus byte
    typedef struct packed {
        logic       read_late; // Bus bit 7, sample MISO half a period later
        logic [6:0] divider;   // Bus bits 6:0
    } spi_cfg_t;

    // One byte handed to the shift engine
    typedef struct packed {
        logic [7:0] data;
        logic       dc;
        logic       end_txn;
    } spi_req_t;

    // Output pins towards the SPI device
    typedef struct packed {
        logic sel;  // Active low select
        logic sclk;
        logic mosi;
        logic dc;   // Data/command line
    } spi_pins_t;

    typedef enum logic [1:0] {ST_IDLE, ST_SCLK_LOW, ST_SCLK_HIGH} spi_state_e;

endpackage

`default_nettype wire

//--- rtl/spi_shift_engine.sv
`default_nettype none
`timescale 1ns/100ps

module spi_shift_engine (
    input  wire                    clk,
    input  wire                    rstn,
    input  wire spi_link_pkg::spi_cfg_t cfg,   // Divider and sampling mode, level
    input  wire spi_link_pkg::spi_req_t req,   // Byte to send, read at start
    input  wire                    start,      // One-cycle pulse, accepted when seen
    input  wire                    miso,
    output spi_link_pkg::spi_pins_t pins,
    output logic                   busy,
    output logic [7:0]             rx_data
);

    import spi_link_pkg::*;

    spi_state_e state;
    logic [6:0] clk_cnt;  // Counts clk cycles within a half period
    logic [3:0] bit_cnt;  // Falling edges still to come
    logic [7:0] shreg;    // Out on the top bit, in on the bottom bit
    logic       sel_q;
    logic       dc_q;
    logic       end_q;    // Latched end_txn of the byte in flight
    logic       half_done;

    // Half period ends when the counter reaches the divider
    assign half_done = (clk_cnt == cfg.divider);

    // Half period counter, runs only during a byte
    always_ff @(posedge clk) begin
        if (!rstn) begin
            clk_cnt <= '0;
        end else if (state == ST_IDLE) begin
            clk_cnt <= '0;
        end else if (half_done) begin
            clk_cnt <= '0;
        end else begin
            clk_cnt <= clk_cnt + 7'd1;
        end
    end

    // Byte FSM
    // sclk low half, then high half, eight times, plus a closing low half
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state   <= ST_IDLE;
            bit_cnt <= '0;
            shreg   <= '0;      // Keeps mosi low until the first byte
            sel_q   <= 1'b1;
            dc_q    <= 1'b0;
            end_q   <= 1'b1;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state   <= ST_SCLK_LOW;
                        shreg   <= req.data;
                        dc_q    <= req.dc;
                        end_q   <= req.end_txn;
                        bit_cnt <= 4'd8;
                        sel_q   <= 1'b0;  // Select asserts with busy
                    end
                end
                ST_SCLK_LOW: begin
                    if (half_done) begin
                        // Late mode replaces the bit taken at the previous fall
                        if (cfg.read_late && !bit_cnt[3]) begin
                            shreg[0] <= miso;
                        end
                        if (bit_cnt == 4'd0) begin
                            state <= ST_IDLE;   // 17th half period done
                            sel_q <= end_q;     // Hold select low for multi-byte
                        end else begin
                            state <= ST_SCLK_HIGH; // Rising sclk edge
                        end
                    end
                end
                ST_SCLK_HIGH: begin
                    if (half_done) begin
                        state   <= ST_SCLK_LOW;       // Falling edge
                        shreg   <= {shreg[6:0], miso}; // MOSI moves, MISO enters
                        bit_cnt <= bit_cnt - 4'd1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    assign busy    = (state != ST_IDLE);
    assign rx_data = shreg;  // Valid once busy is low

    // Pin map
    assign pins.sel  = sel_q;
    assign pins.sclk = (state == ST_SCLK_HIGH);
    assign pins.mosi = shreg[7];  // Top bit, stable across each rise
    assign pins.dc   = dc_q;

endmodule

`default_nettype wire

//--- rtl/spi_reg_block.sv
`default_nettype none
`timescale 1ns/100ps

module spi_reg_block (
    input  wire                                clk,
    input  wire                                rstn,
    input  wire spi_bus_pkg::spi_addr_e        address,
    input  wire                                data_write,  // Write strobe, one cycle per write
    input  wire [spi_bus_pkg::BUS_W-1:0]       data_in,
    output logic [spi_bus_pkg::BUS_W-1:0]      data_out,    // Combinational from address
    input  wire                                busy,
    input  wire [7:0]                          rx_data,
    output spi_link_pkg::spi_cfg_t             cfg,
    output spi_link_pkg::spi_req_t             req,
    output logic                               start
);

    import spi_bus_pkg::*;
    import spi_link_pkg::*;

    spi_ctrl_t   ctrl;        // dc and end_txn for the next byte
    logic [7:0]  tx_data;     // Pending byte, also read back at ADDR_TX
    logic        tx_pending;
    spi_status_t status;

    // Hand the byte over when idle and the bus is quiet
    assign start = tx_pending && !busy && !data_write;

    // Control fields and the one-byte queue
    always_ff @(posedge clk) begin
        if (!rstn) begin
            ctrl.dc      <= 1'b0;
            ctrl.end_txn <= 1'b1;  // Single bytes by default
            tx_pending   <= 1'b0;
        end else if (data_write) begin
            case (address)
                ADDR_CTRL: ctrl <= spi_ctrl_t'(data_in[3:2]);
                ADDR_TX:   tx_pending <= 1'b1;  // Overwrites a byte still waiting
                default:   ;
            endcase
        end else if (start) begin
            tx_pending <= 1'b0;  // Engine takes the byte at this edge
        end
    end

    // Transmit byte, payload only
    always_ff @(posedge clk) begin
        if (data_write && address == ADDR_TX) begin
            tx_data <= data_in;
        end
    end

    // Link configuration
    // A write here applies at once, even mid-byte
    always_ff @(posedge clk) begin
        if (!rstn) begin
            cfg.read_late <= 1'b0;
            cfg.divider   <= CFG_RESET_DIV;
        end else if (data_write && address == ADDR_CFG) begin
            cfg <= spi_cfg_t'(data_in);
        end
    end

    // Request towards the engine, sampled only on start
    assign req.data    = tx_data;
    assign req.dc      = ctrl.dc;
    assign req.end_txn = ctrl.end_txn;

    // Status packing
    always_comb begin
        status.rsvd       = 4'b0000;
        status.dc         = ctrl.dc;
        status.end_txn    = ctrl.end_txn;
        status.tx_pending = tx_pending;
        status.busy       = busy;
    end

    // Read mux, config is write only
    always_comb begin
        case (address)
            ADDR_CTRL: data_out = status;
            ADDR_TX:   data_out = tx_data;
            ADDR_RX:   data_out = rx_data;
            default:   data_out = '0;  // Unmapped reads as zero
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/spi_periph_top.sv
`default_nettype none
`timescale 1ns/100ps

module spi_periph_top (
    input  wire                           clk,
    input  wire                           rstn,
    input  wire [3:0]                     address,     // Raw bus address
    input  wire                           data_write,
    input  wire [spi_bus_pkg::BUS_W-1:0]  data_in,
    output logic [spi_bus_pkg::BUS_W-1:0] data_out,
    input  wire                           miso,
    output spi_link_pkg::spi_pins_t       pins
);

    import spi_bus_pkg::*;
    import spi_link_pkg::*;

    // Register block to engine
    spi_cfg_t   cfg;
    spi_req_t   req;
    logic       start;
    // Engine back to register block
    logic       busy;
    logic [7:0] rx_data;

    spi_reg_block u_regs (
        .clk        (clk),
        .rstn       (rstn),
        .address    (spi_addr_e'(address)),  // Unmapped codes fall to the default read
        .data_write (data_write),
        .data_in    (data_in),
        .data_out   (data_out),
        .busy       (busy),
        .rx_data    (rx_data),
        .cfg        (cfg),
        .req        (req),
        .start      (start)
    );

    spi_shift_engine u_engine (
        .clk     (clk),
        .rstn    (rstn),
        .cfg     (cfg),
        .req     (req),
        .start   (start),
        .miso    (miso),
        .pins    (pins),
        .busy    (busy),
        .rx_data (rx_data)
    );

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
`default_nettype none
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic rstn
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reset low for the first 8 rising edges
    initial begin
        rstn = 1'b0;
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
    end

endmodule

`default_nettype wire

//--- verif/spi_periph_props.sv
`default_nettype none
`timescale 1ns/100ps

module spi_periph_props (
    input wire                          clk,
    input wire                          rstn,
    input wire spi_link_pkg::spi_pins_t pins,
    input wire                          busy   // Engine level from inside the top
);

    int fail_count = 0;  // Failed assertion attempts

    // Serial clock parks low while the device is deselected
    sclk_low_when_deselected: assert property (@(posedge clk) disable iff (!rstn)
        pins.sel |-> !pins.sclk)
        else begin
            $error("sclk high while sel is high");
            fail_count++;
        end

    // Select stays low for the whole byte
    sel_low_while_busy: assert property (@(posedge clk) disable iff (!rstn)
        busy |-> !pins.sel)
        else begin
            $error("sel high while the engine is busy");
            fail_count++;
        end

    // No pin moves over two idle samples in a row
    pins_quiet_when_idle: assert property (@(posedge clk) disable iff (!rstn)
        (!busy && !$past(busy)) |-> $stable(pins))
        else begin
            $error("pins changed while the engine was idle");
            fail_count++;
        end

    // Device takes mosi on the rise
    mosi_stable_while_high: assert property (@(posedge clk) disable iff (!rstn)
        pins.sclk |-> $stable(pins.mosi))
        else begin
            $error("mosi changed while sclk was high");
            fail_count++;
        end

endmodule

`default_nettype wire

//--- verif/tb_spi_periph.sv
`default_nettype none
`timescale 1ns/100ps

module tb_spi_periph;

    import spi_bus_pkg::*;
    import spi_link_pkg::*;

    // 12 bytes at worst divider 2 plus margin for bus cycles
    localparam int BYTE_COUNT  = 12;
    localparam int CYCLE_LIMIT = BYTE_COUNT * 17 * (2 + 1) + 200;

    logic        clk, rstn, data_write, miso;
    logic [3:0]  address;
    logic [7:0]  data_in, data_out;
    spi_pins_t   pins;
    int          errors = 0;
    int          cycles = 0;
    logic [15:0] lfsr = 16'd53;     // Seed

    // Device model state
    logic [7:0]  dev_tx_q[$];       // One answer per byte
    logic [7:0]  dev_rx_q[$];       // Bytes collected from mosi
    logic [7:0]  dev_cur, dev_shift;
    logic [2:0]  rise_idx, out_idx;
    logic        sclk_prev, sel_prev;
    logic        dev_late = 1'b0;   // Lagging device answers after falls
    int          sel_falls, sel_rises;

    tb_clock_gen clkgen0 (.clk(clk), .rstn(rstn));
    spi_periph_top dut0 (.*);
    bind spi_periph_top spi_periph_props props0 (.clk(clk), .rstn(rstn), .pins(pins), .busy(busy));

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d clock cycles, the DUT never went idle", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Mode 0 SPI device that sees the pins as they were before each clk edge
    always @(posedge clk) begin
        if (!rstn) begin
            rise_idx  <= 3'd0;
            out_idx   <= 3'd0;
            sclk_prev <= 1'b0;
            sel_prev  <= 1'b1;
            sel_falls <= 0;
            sel_rises <= 0;
        end else begin
            sclk_prev <= pins.sclk;
            sel_prev  <= pins.sel;
            if (sel_prev && !pins.sel) sel_falls <= sel_falls + 1;
            if (!sel_prev && pins.sel) sel_rises <= sel_rises + 1;
            if (pins.sclk && !sclk_prev) begin      // Rise takes mosi
                dev_shift = {dev_shift[6:0], pins.mosi};
                rise_idx <= rise_idx + 3'd1;
                if (rise_idx == 3'd7) dev_rx_q.push_back(dev_shift);
            end
            // Early device answers after rises, lagging device after falls
            if (pins.sclk != sclk_prev && pins.sclk != dev_late) begin
                if (out_idx == 3'd0) begin
                    dev_cur = 8'h00;                // Nothing queued answers zero
                    if (dev_tx_q.size() > 0) dev_cur = dev_tx_q.pop_front();
                end
                miso    <= dev_cur[3'd7 - out_idx]; // MSB first
                out_idx <= out_idx + 3'd1;
            end
        end
    end

    // Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic rand_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            b    = {b[6:0], lfsr[0]};  // One step per bit
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // Starts and ends on a rising edge; back-to-back calls keep the strobe high
    task automatic bus_write(input logic [3:0] addr, input logic [7:0] data);
        address    <= addr;
        data_in    <= data;
        data_write <= 1'b1;
        @(posedge clk);
        data_write <= 1'b0;
    endtask

    task automatic bus_read(input logic [3:0] addr, output logic [7:0] data);
        address    <= addr;
        data_write <= 1'b0;
        @(posedge clk);
        data = data_out;  // Settled value from before the edge
    endtask

    // Idle also needs the queue empty
    task automatic poll_busy(input logic level);
        spi_status_t st;
        do begin
            bus_read(ADDR_CTRL, st);
        end while (st.busy != level || (!level && st.tx_pending));
    endtask

    task automatic send_byte(input logic [7:0] tx, input logic [7:0] dev);
        dev_tx_q.push_back(dev);
        bus_write(ADDR_TX, tx);
        poll_busy(1'b0);
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_status(input spi_status_t got, input spi_status_t exp,
                                input string what);
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t: %s status %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_pins(input spi_pins_t got, input spi_pins_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t: %s sel/sclk/mosi/dc %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_mosi(input logic [7:0] tx);
        if (dev_rx_q.size() == 0) begin
            errors++;
            $display("Device model collected no byte for %h at %0t", tx, $time);
        end else begin
            check_byte(dev_rx_q.pop_front(), tx, "byte seen by device");
        end
    endtask

    task automatic check_transfer(input logic [7:0] tx, input logic [7:0] dev);
        logic [7:0] rd;
        check_mosi(tx);
        bus_read(ADDR_RX, rd);
        check_byte(rd, dev, "ADDR_RX");
    endtask

    task automatic reset_values;
        logic [7:0] rd;
        bus_read(ADDR_CTRL, rd);
        check_status(rd, spi_status_t'{4'h0, 1'b0, 1'b1, 1'b0, 1'b0}, "status after reset");
        check_pins(pins, spi_pins_t'{1'b1, 1'b0, 1'b0, 1'b0}, "pins after reset");
        bus_read(4'd9, rd);
        check_byte(rd, 8'h00, "unmapped address");
    endtask

    task automatic single_byte;
        logic [7:0] tx, dev, rd;
        rand_byte(tx);
        rand_byte(dev);
        bus_write(ADDR_CFG, 8'h01);   // Divider 1 with early sampling
        bus_write(ADDR_CTRL, 8'h04);  // dc 0 and end_txn 1
        send_byte(tx, dev);
        check_transfer(tx, dev);
        check_pins(pins, spi_pins_t'{1'b1, 1'b0, dev[7], 1'b0}, "select released");
        bus_read(ADDR_TX, rd);
        check_byte(rd, tx, "ADDR_TX readback");
    endtask

    task automatic held_select;
        logic [7:0] tx, dev;
        int falls0, rises0;
        falls0 = sel_falls;
        rises0 = sel_rises;
        bus_write(ADDR_CTRL, 8'h08);  // dc 1 and select stays low
        for (int i = 0; i < 4; i++) begin
            if (i == 3) bus_write(ADDR_CTRL, 8'h0C);  // Last byte closes the transaction
            rand_byte(tx);
            rand_byte(dev);
            send_byte(tx, dev);
            check_transfer(tx, dev);
            check_pins(pins, spi_pins_t'{i == 3, 1'b0, dev[7], 1'b1}, "multi-byte pins");
        end
        check_byte(8'(sel_falls - falls0), 8'd1, "select falls");
        check_byte(8'(sel_rises - rises0), 8'd1, "select rises");
    endtask

    task automatic tx_overwrite;
        logic [7:0] first, second, dev, rd;
        rand_byte(first);
        rand_byte(second);
        rand_byte(dev);
        bus_write(ADDR_CTRL, 8'h04);
        dev_tx_q.push_back(dev);
        bus_write(ADDR_TX, first);
        bus_write(ADDR_TX, second);   // Same strobe run replaces the first
        bus_read(ADDR_CTRL, rd);
        check_status(rd, spi_status_t'{4'h0, 1'b0, 1'b1, 1'b1, 1'b0}, "pending before start");
        poll_busy(1'b0);
        check_transfer(second, dev);
        check_byte(8'(dev_rx_q.size()), 8'd0, "bytes left at device");
    endtask

    task automatic queued_byte;
        logic [7:0] a, b, da, db, rd;
        rand_byte(a);
        rand_byte(b);
        rand_byte(da);
        rand_byte(db);
        dev_tx_q.push_back(da);
        dev_tx_q.push_back(db);
        bus_write(ADDR_TX, a);
        poll_busy(1'b1);
        bus_write(ADDR_TX, b);        // Waits behind the byte in flight
        bus_read(ADDR_CTRL, rd);
        check_status(rd, spi_status_t'{4'h0, 1'b0, 1'b1, 1'b1, 1'b1}, "queued while busy");
        poll_busy(1'b0);              // Reads only from here
        check_mosi(a);
        check_transfer(b, db);
    endtask

    task automatic late_sampling;
        logic [7:0] tx, dev;
        bus_write(ADDR_CFG, 8'h82);   // Divider 2 with late sampling
        dev_late <= 1'b1;
        for (int i = 0; i < 4; i++) begin
            rand_byte(tx);
            rand_byte(dev);
            send_byte(tx, dev);
            check_transfer(tx, dev);
        end
    endtask

    initial begin
        address    = 4'd0;
        data_write = 1'b0;
        data_in    = 8'h00;
        miso       = 1'b0;
        @(posedge rstn);
        @(posedge clk);
        reset_values;
        single_byte;
        held_select;
        tx_overwrite;
        queued_byte;
        late_sampling;
        $display("Errors: %0d in checks, %0d in assertions", errors, dut0.props0.fail_count);
        if (errors == 0 && dut0.props0.fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
rtl/spi_bus_pkg.sv
rtl/spi_link_pkg.sv
rtl/spi_shift_engine.sv
rtl/spi_reg_block.sv
rtl/spi_periph_top.sv
verif/tb_clock_gen.sv
verif/spi_periph_props.sv
verif/tb_spi_periph.sv
